//--- hdl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_idx_t;   // Registers a..h

    // Unlisted codes fall through to nop in the ALU
    typedef enum logic [4:0] {
        op_nop         = 5'd0,
        op_add         = 5'd1,
        op_sub         = 5'd2,
        op_and         = 5'd3,
        op_or          = 5'd4,
        op_xor         = 5'd5,
        op_shl         = 5'd6,
        op_shr         = 5'd7,
        op_cmp_eq      = 5'd8,
        op_cmp_lt      = 5'd9,    // Unsigned
        op_load_imm    = 5'd10,
        op_load        = 5'd11,
        op_store       = 5'd12,
        op_jump        = 5'd13,
        op_branch_flag = 5'd14,
        op_halt        = 5'd15
    } opcode_t;

    typedef struct packed {
        logic        spare;
        logic [15:0] imm;
        logic        high_half;   // load_imm into upper half
        reg_idx_t    rb;
        reg_idx_t    ra;
        reg_idx_t    rd;
        opcode_t     opcode;
    } instr_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_halted
    } fsm_state_t;

    typedef struct packed {
        word_t result;
        logic  flag;
        logic  write_value;     // Write intents for rd
        logic  write_flag;
        logic  branch_taken;
        word_t target;          // Next pc
    } alu_out_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_rsp_t;

endpackage

//--- hdl/register_file.sv
module register_file
    import cpu_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t read_a_idx,
    input  reg_idx_t read_b_idx,
    input  reg_idx_t write_idx,
    input  logic     write_value_en,
    input  logic     write_flag_en,
    input  word_t    write_value,
    input  logic     write_flag,
    output word_t    read_a,
    output word_t    read_b,
    output logic     flag_a,
    output logic     flag_b
);

    word_t      regs [0:7];
    logic [7:0] flags;

    // Value and flag have separate enables so compares only touch the flag
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (write_value_en) begin
                regs[write_idx] <= write_value;
            end
            if (write_flag_en) begin
                flags[write_idx] <= write_flag;
            end
        end
    end

    assign read_a = regs[read_a_idx];
    assign read_b = regs[read_b_idx];
    assign flag_a = flags[read_a_idx];
    assign flag_b = flags[read_b_idx];

endmodule

//--- hdl/alu.sv
module alu
    import cpu_pkg::*;
(
    input  instr_t   instr,
    input  word_t    operand_a,
    input  word_t    operand_b,
    input  logic     flag_a,
    input  word_t    pc,
    output alu_out_t out
);

    word_t imm_ext;
    word_t next_pc;
    logic  zero_flag_op;    // Result written, flag = result is zero

    assign imm_ext = {16'h0000, instr.imm};
    assign next_pc = pc + 32'd1;

    always_comb begin
        out = '{
            result:       operand_a,
            flag:         1'b0,
            write_value:  1'b0,
            write_flag:   1'b0,
            branch_taken: 1'b0,
            target:       next_pc
        };
        zero_flag_op = 1'b0;

        case (instr.opcode)
            op_add: begin
                out.result   = operand_a + operand_b;
                zero_flag_op = 1'b1;
            end
            op_sub: begin
                out.result   = operand_a - operand_b;
                zero_flag_op = 1'b1;
            end
            op_and: begin
                out.result   = operand_a & operand_b;
                zero_flag_op = 1'b1;
            end
            op_or: begin
                out.result   = operand_a | operand_b;
                zero_flag_op = 1'b1;
            end
            op_xor: begin
                out.result   = operand_a ^ operand_b;
                zero_flag_op = 1'b1;
            end
            op_shl: begin
                out.result   = operand_a << operand_b[4:0];
                zero_flag_op = 1'b1;
            end
            op_shr: begin
                out.result   = operand_a >> operand_b[4:0];
                zero_flag_op = 1'b1;
            end
            op_cmp_eq: begin
                out.flag       = operand_a == operand_b;
                out.write_flag = 1'b1;
            end
            op_cmp_lt: begin
                out.flag       = operand_a < operand_b;
                out.write_flag = 1'b1;
            end
            op_load_imm: begin
                // Upper half keeps lower half of ra
                out.result      = instr.high_half ? {instr.imm, operand_a[15:0]} : imm_ext;
                out.write_value = 1'b1;
            end
            op_load: begin
                out.write_value = 1'b1;   // Data arrives later from the bus
                out.write_flag  = 1'b1;
            end
            op_jump:        out.branch_taken = 1'b1;
            op_branch_flag: out.branch_taken = flag_a;
            default: ;                    // nop, store, halt
        endcase

        if (zero_flag_op) begin
            out.write_value = 1'b1;
            out.write_flag  = 1'b1;
            out.flag        = out.result == '0;
        end
        if (out.branch_taken) begin
            out.target = imm_ext;
        end
    end

endmodule

//--- hdl/control_fsm.sv
module control_fsm
    import cpu_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  wb_rsp_t  bus_rsp,
    output wb_req_t  bus_req,
    input  alu_out_t alu_out,
    input  word_t    operand_a,
    input  word_t    operand_b,
    output instr_t   instr,
    output word_t    pc,
    output reg_idx_t read_a_idx,
    output reg_idx_t read_b_idx,
    output reg_idx_t write_idx,
    output logic     write_value_en,
    output logic     write_flag_en,
    output word_t    write_value,
    output logic     write_flag,
    output logic     halted
);

    fsm_state_t state;
    logic       req_active;   // cyc and stb together
    logic       req_we;
    word_t      req_adr;
    word_t      req_dat;
    logic       is_mem;
    logic       mem_ack;

    assign is_mem  = instr.opcode inside {op_load, op_store};
    assign mem_ack = state == st_memory && bus_rsp.ack;
    assign halted  = state == st_halted;

    assign bus_req = '{cyc: req_active, stb: req_active, we: req_we,
                       adr: req_adr, dat: req_dat};

    assign read_a_idx = instr.ra;
    assign read_b_idx = instr.rb;
    assign write_idx  = instr.rd;

    // Memory ops write rd only when the load data is acked
    assign write_value_en = alu_out.write_value && ((state == st_execute && !is_mem) || mem_ack);
    assign write_flag_en  = alu_out.write_flag && ((state == st_execute && !is_mem) || mem_ack);
    assign write_value    = (state == st_memory) ? bus_rsp.dat : alu_out.result;
    assign write_flag     = alu_out.flag;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_fetch;
            pc         <= '0;
            req_active <= 1'b0;
            req_we     <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!req_active) begin
                        req_active <= 1'b1;
                        req_we     <= 1'b0;
                    end else if (bus_rsp.ack) begin
                        req_active <= 1'b0;
                        state      <= st_execute;
                    end
                end
                st_execute: begin
                    if (is_mem) begin
                        req_active <= 1'b1;
                        req_we     <= instr.opcode == op_store;
                        state      <= st_memory;
                    end else if (instr.opcode == op_halt) begin
                        state <= st_halted;
                    end else begin
                        pc         <= alu_out.target;
                        req_active <= 1'b1;   // Next fetch straight away
                        req_we     <= 1'b0;
                        state      <= st_fetch;
                    end
                end
                st_memory: begin
                    if (bus_rsp.ack) begin
                        req_active <= 1'b0;
                        req_we     <= 1'b0;
                        pc         <= pc + 32'd1;
                        state      <= st_fetch;
                    end
                end
                default: ;                    // Halted until reset
            endcase
        end
    end

    // Instruction register and request payload
    always_ff @(posedge clock) begin
        if (state == st_fetch && req_active && bus_rsp.ack) begin
            instr <= instr_t'(bus_rsp.dat);
        end
        if (state == st_fetch && !req_active) begin
            req_adr <= pc;
        end else if (state == st_execute) begin
            req_adr <= is_mem ? operand_a : alu_out.target;
            req_dat <= operand_b;
        end
    end

    drop_after_ack: assert property (@(posedge clock) disable iff (reset)
        bus_req.cyc && bus_req.stb && bus_rsp.ack |=> !bus_req.cyc && !bus_req.stb);

    req_held_until_ack: assert property (@(posedge clock) disable iff (reset)
        bus_req.stb && !bus_rsp.ack |=> bus_req.stb && $stable(bus_req.adr)
            && $stable(bus_req.we) && $stable(bus_req.dat));

    // Checks the ALU decode against the opcode held here
    no_value_write_cmp_store: assert property (@(posedge clock) disable iff (reset)
        state == st_execute && instr.opcode inside {op_cmp_eq, op_cmp_lt, op_store}
            |-> !alu_out.write_value);

endmodule

//--- hdl/cpu.sv
module cpu
    import cpu_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  wb_rsp_t bus_rsp,
    output wb_req_t bus_req,
    output logic    halted
);

    instr_t   instr;
    word_t    pc;
    alu_out_t alu_out;
    reg_idx_t read_a_idx;
    reg_idx_t read_b_idx;
    reg_idx_t write_idx;
    logic     write_value_en;
    logic     write_flag_en;
    word_t    write_value;
    logic     write_flag;
    word_t    read_a;
    word_t    read_b;
    logic     flag_a;

    control_fsm control_fsm_i (
        .clock          (clock),
        .reset          (reset),
        .bus_rsp        (bus_rsp),
        .bus_req        (bus_req),
        .alu_out        (alu_out),
        .operand_a      (read_a),
        .operand_b      (read_b),
        .instr          (instr),
        .pc             (pc),
        .read_a_idx     (read_a_idx),
        .read_b_idx     (read_b_idx),
        .write_idx      (write_idx),
        .write_value_en (write_value_en),
        .write_flag_en  (write_flag_en),
        .write_value    (write_value),
        .write_flag     (write_flag),
        .halted         (halted)
    );

    register_file register_file_i (
        .clock          (clock),
        .reset          (reset),
        .read_a_idx     (read_a_idx),
        .read_b_idx     (read_b_idx),
        .write_idx      (write_idx),
        .write_value_en (write_value_en),
        .write_flag_en  (write_flag_en),
        .write_value    (write_value),
        .write_flag     (write_flag),
        .read_a         (read_a),
        .read_b         (read_b),
        .flag_a         (flag_a),
        .flag_b         ()          // Branches test ra only
    );

    alu alu_i (
        .instr     (instr),
        .operand_a (read_a),
        .operand_b (read_b),
        .flag_a    (flag_a),
        .pc        (pc),
        .out       (alu_out)
    );

endmodule

//--- verification/cpu_model.sv
module cpu_model
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    word_t      mem [0:255];
    word_t      regs [0:7];
    logic [7:0] flags;
    word_t      fetch_queue [$];
    wb_req_t    store_queue [$];

    task automatic load_word(input int addr, input word_t data);
        mem[addr] = data;
    endtask

    task automatic write_result(input reg_idx_t rd, input word_t value);
        regs[rd]  = value;
        flags[rd] = value == '0;
    endtask

    // Runs the whole program at instruction level, one step per instruction
    task automatic run(input int max_steps, output logic reached_halt);
        word_t  pc;
        word_t  a;
        word_t  b;
        instr_t ins;
        pc           = '0;
        flags        = '0;
        reached_halt = 1'b0;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int step = 0; step < max_steps && !reached_halt; step++) begin
            fetch_queue.push_back(pc);
            ins = instr_t'(mem[pc[7:0]]);
            a   = regs[ins.ra];
            b   = regs[ins.rb];
            pc  = pc + 32'd1;
            case (ins.opcode)
                op_add:    write_result(ins.rd, a + b);
                op_sub:    write_result(ins.rd, a - b);
                op_and:    write_result(ins.rd, a & b);
                op_or:     write_result(ins.rd, a | b);
                op_xor:    write_result(ins.rd, a ^ b);
                op_shl:    write_result(ins.rd, a << b[4:0]);
                op_shr:    write_result(ins.rd, a >> b[4:0]);
                op_cmp_eq: flags[ins.rd] = a == b;
                op_cmp_lt: flags[ins.rd] = a < b;
                op_load_imm: begin
                    regs[ins.rd] = ins.high_half ? {ins.imm, a[15:0]} : {16'h0000, ins.imm};
                end
                op_load: begin
                    regs[ins.rd]  = mem[{1'b1, a[6:0]}];   // Data area at 128 + adr mod 128
                    flags[ins.rd] = 1'b0;
                end
                op_store: begin
                    store_queue.push_back('{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: a, dat: b});
                    mem[{1'b1, a[6:0]}] = b;
                end
                op_jump:        pc = {16'h0000, ins.imm};
                op_branch_flag: pc = flags[ins.ra] ? {16'h0000, ins.imm} : pc;
                op_halt:        reached_halt = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic pop_fetch(output word_t adr, output logic found);
        found = fetch_queue.size() > 0;
        adr   = '0;
        if (found) begin
            adr = fetch_queue.pop_front();
        end
    endtask

    task automatic pop_store(output wb_req_t req, output logic found);
        found = store_queue.size() > 0;
        req   = '0;
        if (found) begin
            req = store_queue.pop_front();
        end
    endtask

    function automatic int pending_count();
        return fetch_queue.size() + store_queue.size();
    endfunction

endmodule

//--- verification/cpu_tb.sv
module cpu_tb
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int program_words = 128;
    localparam int reset_cycles  = 16;
    localparam int max_wait      = 3;
    localparam int watch_cycles  = 20;
    // Fetch, execute and data access, each with all wait states
    localparam int watchdog_cycles = reset_cycles + watch_cycles
                                     + program_words * (2 * (max_wait + 2) + 1);

    logic    clock = 1'b0;
    logic    reset;
    wb_rsp_t bus_rsp;
    wb_req_t bus_req;
    logic    halted;
    integer  seed;
    word_t   mem [0:255];
    wb_req_t held;          // Request waiting for ack
    instr_t  fetched;
    logic    busy;
    logic    acked;
    logic    data_phase;    // Next request is the load or store of the last fetch
    int      waits_left;

    cpu dut_i (
        .clock   (clock),
        .reset   (reset),
        .bus_rsp (bus_rsp),
        .bus_req (bus_req),
        .halted  (halted)
    );

    cpu_model model_i ();

    always #50 clock = ~clock;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic string req_text(input wb_req_t r);
        return $sformatf("cyc=%b stb=%b we=%b adr=%h dat=%h", r.cyc, r.stb, r.we, r.adr, r.dat);
    endfunction

    task automatic check_fetch(input word_t actual, input word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t ns: bus_req.adr of fetch is %h, expected %h",
                               $time, actual, expected));
        end
    endtask

    task automatic check_store(input wb_req_t actual, input wb_req_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t ns: bus_req of store is %s, expected %s",
                               $time, req_text(actual), req_text(expected)));
        end
    endtask

    task automatic check_held(input wb_req_t actual, input wb_req_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t ns: bus_req before ack is %s, expected %s",
                               $time, req_text(actual), req_text(expected)));
        end
    endtask

    task automatic check_halted(input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t ns: halted is %b, expected %b",
                               $time, actual, expected));
        end
    endtask

    // Every rd writer is followed by a store of rd, branches only jump forward
    task automatic build_program();
        instr_t ins;
        int     idx;
        int     kind;
        int     span;
        for (int i = 128; i < 256; i++) begin
            mem[i] = {16'hd00d, 8'(i), ~8'(i)};
        end
        idx = 0;
        while (idx < program_words - 1) begin
            ins  = instr_t'($random(seed));
            kind = $unsigned($random(seed)) % 8;
            if (kind <= 4 && idx + 2 > program_words - 1) begin
                kind = 7;                         // No room left for the store
            end
            case (kind)
                0, 1, 2: ins.opcode = opcode_t'(5'(int'(op_add) + $unsigned($random(seed)) % 9));
                3:       ins.opcode = op_load_imm;
                4:       ins.opcode = op_load;
                5:       ins.opcode = op_store;
                6: begin
                    span        = (program_words - 1 - idx > 12) ? 12 : program_words - 1 - idx;
                    ins.opcode  = ($random(seed) & 3) == 0 ? op_jump : op_branch_flag;
                    ins.imm     = 16'(idx + 1 + $unsigned($random(seed)) % span);
                end
                default: ins.opcode = ($random(seed) & 1) ? op_nop
                                      : opcode_t'(5'(16 + $unsigned($random(seed)) % 16));
            endcase
            mem[idx] = ins;
            idx++;
            if (kind <= 4) begin
                ins.opcode = op_store;
                ins.rb     = ins.rd;
                ins.ra     = 3'($random(seed));
                mem[idx]   = ins;
                idx++;
            end
        end
        mem[program_words - 1] = word_t'(op_halt);
    endtask

    task automatic acknowledge();
        if (data_phase) begin
            if (held.we) begin
                mem[{1'b1, held.adr[6:0]}] = held.dat;
            end else begin
                bus_rsp.dat = mem[{1'b1, held.adr[6:0]}];
            end
            data_phase = 1'b0;
        end else begin
            bus_rsp.dat = mem[held.adr[7:0]];
            fetched     = instr_t'(bus_rsp.dat);
            data_phase  = fetched.opcode inside {op_load, op_store};
        end
        bus_rsp.ack = 1'b1;
        busy        = 1'b0;
        acked       = 1'b1;
    endtask

    task automatic accept_request();
        word_t   expected_adr;
        wb_req_t expected_req;
        logic    found;
        held = bus_req;
        if (data_phase && fetched.opcode == op_store) begin
            model_i.pop_store(expected_req, found);
            if (!found) begin
                fail_run("A store appeared that the model does not expect");
            end
            check_store(bus_req, expected_req);
        end else if (bus_req.we) begin
            fail_run($sformatf("A read request at %0t ns has we set", $time));
        end else if (!data_phase) begin
            model_i.pop_fetch(expected_adr, found);
            if (!found) begin
                fail_run("A fetch appeared after the model's program ended");
            end
            check_fetch(bus_req.adr, expected_adr);
        end
        busy       = 1'b1;
        waits_left = $unsigned($random(seed)) % (max_wait + 1);
        if (waits_left == 0) begin
            acknowledge();
        end
    endtask

    // Wishbone memory with 0 to 3 wait states
    always @(negedge clock) begin
        if (reset) begin
            if (bus_req.cyc || bus_req.stb) begin
                fail_run("The bus request is active during reset");
            end
            check_halted(halted, 1'b0);
        end else if (acked) begin
            bus_rsp.ack = 1'b0;
            acked       = 1'b0;
            if (bus_req.cyc || bus_req.stb) begin
                fail_run("The request is still up in the cycle after its ack");
            end
        end else if (busy) begin
            check_held(bus_req, held);
            waits_left--;
            if (waits_left == 0) begin
                acknowledge();
            end
        end else if (bus_req.cyc && bus_req.stb) begin
            accept_request();
        end
    end

    initial begin
        logic model_halted;
        reset      = 1'b1;
        bus_rsp    = '0;
        seed       = 32'h1f5;
        busy       = 1'b0;
        acked      = 1'b0;
        data_phase = 1'b0;
        waits_left = 0;
        build_program();
        for (int i = 0; i < 256; i++) begin
            model_i.load_word(i, mem[i]);
        end
        model_i.run(2 * program_words, model_halted);
        if (!model_halted) begin
            fail_run("The reference model never reached op_halt");
        end
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        while (!halted) @(negedge clock);
        repeat (watch_cycles) begin
            @(negedge clock);
            check_halted(halted, 1'b1);
            if (bus_req.cyc) begin
                fail_run("A bus request appeared after halt");
            end
        end
        if (model_i.pending_count() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected transactions never appeared",
                               model_i.pending_count()));
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        fail_run($sformatf("The CPU did not halt within %0d cycles", watchdog_cycles));
    end

endmodule

//--- filelist.f
hdl/cpu_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/control_fsm.sv
hdl/cpu.sv
verification/cpu_model.sv
verification/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/register_file.sv
      - hdl/alu.sv
      - hdl/control_fsm.sv
      - hdl/cpu.sv
  - target: test
    files:
      - verification/cpu_model.sv
      - verification/cpu_tb.sv
